// ==== design/cctl_seq.sv ====
// cache-control sequencer: command latch and two or three step walk
`default_nettype none
`timescale 1ns/1ps

module cctl_seq (
    input  logic                          core_clk,
    input  logic                          core_reset_n,
    input  logic                          cctl_req,
    input  logic [uop_pkg::CMD_W-1:0]     cctl_cmd,
    input  logic [uop_pkg::REG_W-1:0]     cctl_rs,
    input  logic [uop_pkg::REG_W-1:0]     cctl_rd,
    input  logic                          adv,
    output logic                          want,
    output logic [uop_pkg::PC_W-1:0]      step_pc,
    output logic                          step_last,
    output logic                          busy,
    output logic [uop_pkg::CMD_W-1:0]     cmd_q,
    output logic [uop_pkg::REG_W-1:0]     rs_q,
    output logic [uop_pkg::REG_W-1:0]     rd_q
);

    logic busy_q;
    logic accept;

    assign accept = cctl_req && !busy_q;

    // cmd[7] adds the data read-back step
    assign step_last = (step_pc == 4'd2) || ((step_pc == 4'd1) && !cmd_q[7]);

    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            busy_q  <= 1'b0;
            step_pc <= '0;
        end else if (accept) begin
            busy_q  <= 1'b1;
            step_pc <= '0;
        end else if (adv) begin
            if (step_last) begin
                busy_q <= 1'b0;
            end else begin
                step_pc <= step_pc + 4'd1;
            end
        end
    end

    always_ff @(posedge core_clk) begin
        if (accept) begin
            cmd_q <= cctl_cmd;
            rs_q  <= cctl_rs;
            rd_q  <= cctl_rd;
        end
    end

    assign want = busy_q;
    assign busy = busy_q;

endmodule

`default_nettype wire

// ==== design/pp_seq.sv ====
// push/pop sequencer: request latch and program-buffer step walk
`default_nettype none
`timescale 1ns/1ps

module pp_seq (
    input  logic                             core_clk,
    input  logic                             core_reset_n,
    input  logic                             pp_req,
    input  logic [uop_pkg::KIND_W-1:0]       pp_kind,
    input  logic [uop_pkg::CNT_W-1:0]        pp_rcount,
    input  logic [uop_pkg::IMM_W-1:0]        pp_stackadj,
    input  logic                             adv,
    output logic                             want,
    output logic [uop_pkg::PC_W-1:0]         step_pc,
    output logic                             step_last,
    output logic                             busy,
    output logic [uop_pkg::KIND_W-1:0]       kind_q,
    output logic [uop_pkg::CNT_W-1:0]        rcount_q,
    output logic [uop_pkg::IMM_W-1:0]        stackadj_q
);

    logic                        busy_q;
    logic                        accept;
    logic [uop_pkg::PC_W-1:0]    next_pc;

    assign accept = pp_req && !busy_q;     // strobes while busy are dropped

    // slots 0..rcount-1, then adjust, then return for popret
    always_comb begin
        if (step_pc == uop_pkg::PP_STEP_ADJ) begin
            next_pc = uop_pkg::PP_STEP_RET;
        end else if (step_pc == rcount_q - 4'd1) begin
            next_pc = uop_pkg::PP_STEP_ADJ;
        end else begin
            next_pc = step_pc + 4'd1;
        end
    end

    assign step_last = (step_pc == uop_pkg::PP_STEP_RET) ||
                       ((step_pc == uop_pkg::PP_STEP_ADJ) && (kind_q != uop_pkg::PP_POPRET));

    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            busy_q  <= 1'b0;
            step_pc <= '0;
        end else if (accept) begin
            busy_q  <= 1'b1;
            step_pc <= '0;
        end else if (adv) begin
            if (step_last) begin
                busy_q <= 1'b0;             // last word now in issue register
            end else begin
                step_pc <= next_pc;
            end
        end
    end

    always_ff @(posedge core_clk) begin
        if (accept) begin
            kind_q     <= pp_kind;
            rcount_q   <= pp_rcount;
            stackadj_q <= pp_stackadj;
        end
    end

    assign want = busy_q;
    assign busy = busy_q;

    // the arbiter only consumes steps from a live sequence
    adv_needs_want: assert property (
        @(posedge core_clk) disable iff (!core_reset_n) adv |-> want
    );

endmodule

`default_nettype wire

// ==== design/uop_arbiter.sv ====
// round-robin program-buffer arbiter with whole-sequence lock
`default_nettype none
`timescale 1ns/1ps

module uop_arbiter (
    input  logic                          core_clk,
    input  logic                          core_reset_n,
    input  logic                          uop_stall,
    input  logic                          pp_want,
    input  logic [uop_pkg::PC_W-1:0]      pp_pc,
    input  logic                          pp_last,
    input  logic                          cctl_want,
    input  logic [uop_pkg::PC_W-1:0]      cctl_pc,
    input  logic                          cctl_last,
    input  logic                          buf_free,
    output logic                          pp_adv,
    output logic                          cctl_adv,
    output logic                          buf_load,
    output logic [uop_pkg::PC_W-1:0]      buf_pc,
    output logic                          buf_owner,
    output logic                          buf_last
);

    logic [1:0] state_q;
    logic       owner_q;
    logic       pref_q;         // requester that wins a tie
    logic       pick;
    logic       cur;
    logic       cur_want;
    logic       adv_any;

    assign pick = (pp_want && cctl_want) ? pref_q :
                  (cctl_want ? uop_pkg::REQ_CCTL : uop_pkg::REQ_PP);
    assign cur  = (state_q == uop_pkg::ARB_IDLE) ? pick : owner_q;

    assign cur_want  = (cur == uop_pkg::REQ_CCTL) ? cctl_want : pp_want;
    assign buf_pc    = (cur == uop_pkg::REQ_CCTL) ? cctl_pc : pp_pc;
    assign buf_last  = (cur == uop_pkg::REQ_CCTL) ? cctl_last : pp_last;
    assign buf_owner = cur;

    assign buf_load = !uop_stall && cur_want &&
                      ((state_q == uop_pkg::ARB_RUN) ||
                       ((state_q == uop_pkg::ARB_IDLE) && buf_free));

    // final step is released once its word leaves the program buffer
    assign adv_any  = (buf_load && !buf_last) || ((state_q == uop_pkg::ARB_DRAIN) && buf_free);
    assign pp_adv   = adv_any && (cur == uop_pkg::REQ_PP);
    assign cctl_adv = adv_any && (cur == uop_pkg::REQ_CCTL);

    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            state_q <= uop_pkg::ARB_IDLE;
            owner_q <= uop_pkg::REQ_PP;
            pref_q  <= uop_pkg::REQ_PP;
        end else begin
            case (state_q)
                uop_pkg::ARB_IDLE: if (buf_load) begin
                    owner_q <= cur;
                    pref_q  <= (cur == uop_pkg::REQ_PP) ? uop_pkg::REQ_CCTL : uop_pkg::REQ_PP;
                    state_q <= buf_last ? uop_pkg::ARB_DRAIN : uop_pkg::ARB_RUN;
                end
                uop_pkg::ARB_RUN: if (buf_load && buf_last) begin
                    state_q <= uop_pkg::ARB_DRAIN;
                end
                default: if (buf_free) begin
                    state_q <= uop_pkg::ARB_IDLE;
                end
            endcase
        end
    end

    // the locked owner keeps its request up until its last step drains
    lock_holds_want: assert property (
        @(posedge core_clk) disable iff (!core_reset_n)
        (state_q != uop_pkg::ARB_IDLE) |-> cur_want
    );

endmodule

`default_nettype wire

// ==== design/uop_expander.sv ====
// micro-op expander top: push/pop and cache-control sequencers, arbiter, program buffer
`default_nettype none
`timescale 1ns/1ps

module uop_expander (
    input  logic                          core_clk,
    input  logic                          core_reset_n,
    input  logic                          uop_stall,
    input  logic                          pp_req,
    input  logic [uop_pkg::KIND_W-1:0]    pp_kind,
    input  logic [uop_pkg::CNT_W-1:0]     pp_rcount,
    input  logic [uop_pkg::IMM_W-1:0]     pp_stackadj,
    input  logic                          cctl_req,
    input  logic [uop_pkg::CMD_W-1:0]     cctl_cmd,
    input  logic [uop_pkg::REG_W-1:0]     cctl_rs,
    input  logic [uop_pkg::REG_W-1:0]     cctl_rd,
    input  logic                          priv_m,
    output logic                          pp_busy,
    output logic                          cctl_busy,
    output logic                          uop_valid,
    output uop_pkg::uop_word_u            uop_word
);

    logic                        pp_want;
    logic [uop_pkg::PC_W-1:0]    pp_pc;
    logic                        pp_last;
    logic                        pp_adv;
    logic [uop_pkg::KIND_W-1:0]  kind_q;
    logic [uop_pkg::CNT_W-1:0]   rcount_q;
    logic [uop_pkg::IMM_W-1:0]   stackadj_q;
    logic                        cctl_want;
    logic [uop_pkg::PC_W-1:0]    cctl_pc;
    logic                        cctl_last;
    logic                        cctl_adv;
    logic [uop_pkg::CMD_W-1:0]   cmd_q;
    logic [uop_pkg::REG_W-1:0]   rs_q;
    logic [uop_pkg::REG_W-1:0]   rd_q;
    logic                        buf_load;
    logic [uop_pkg::PC_W-1:0]    buf_pc;
    logic                        buf_owner;
    logic                        buf_last;
    logic                        buf_free;

    pp_seq u_pp_seq (
        .core_clk(core_clk), .core_reset_n(core_reset_n),
        .pp_req(pp_req), .pp_kind(pp_kind), .pp_rcount(pp_rcount), .pp_stackadj(pp_stackadj),
        .adv(pp_adv), .want(pp_want), .step_pc(pp_pc), .step_last(pp_last), .busy(pp_busy),
        .kind_q(kind_q), .rcount_q(rcount_q), .stackadj_q(stackadj_q)
    );

    cctl_seq u_cctl_seq (
        .core_clk(core_clk), .core_reset_n(core_reset_n),
        .cctl_req(cctl_req), .cctl_cmd(cctl_cmd), .cctl_rs(cctl_rs), .cctl_rd(cctl_rd),
        .adv(cctl_adv), .want(cctl_want), .step_pc(cctl_pc), .step_last(cctl_last),
        .busy(cctl_busy), .cmd_q(cmd_q), .rs_q(rs_q), .rd_q(rd_q)
    );

    uop_arbiter u_arbiter (
        .core_clk(core_clk), .core_reset_n(core_reset_n), .uop_stall(uop_stall),
        .pp_want(pp_want), .pp_pc(pp_pc), .pp_last(pp_last),
        .cctl_want(cctl_want), .cctl_pc(cctl_pc), .cctl_last(cctl_last),
        .buf_free(buf_free), .pp_adv(pp_adv), .cctl_adv(cctl_adv), .buf_load(buf_load),
        .buf_pc(buf_pc), .buf_owner(buf_owner), .buf_last(buf_last)
    );

    uop_prgbuf u_prgbuf (
        .core_clk(core_clk), .core_reset_n(core_reset_n), .uop_stall(uop_stall),
        .buf_load(buf_load), .buf_pc(buf_pc), .buf_owner(buf_owner), .buf_last(buf_last),
        .priv_m(priv_m), .pp_kind(kind_q), .pp_rcount(rcount_q), .pp_stackadj(stackadj_q),
        .cctl_cmd(cmd_q), .cctl_rs(rs_q), .cctl_rd(rd_q),
        .buf_free(buf_free), .uop_valid(uop_valid), .uop_word(uop_word)
    );

endmodule

`default_nettype wire

// ==== design/uop_pkg.sv ====
// micro-op word union, field widths, op classes, CSR addresses, requester ids, step map
`default_nettype none

package uop_pkg;

    localparam int UOP_W  = 41;
    localparam int PC_W   = 4;
    localparam int REG_W  = 5;
    localparam int OP_W   = 16;
    localparam int IMM_W  = 12;
    localparam int KIND_W = 2;
    localparam int CNT_W  = 4;
    localparam int CMD_W  = 8;

    // one-hot op classes
    localparam logic [OP_W-1:0] OP_STORE = 16'h8000;
    localparam logic [OP_W-1:0] OP_LOAD  = 16'h4000;
    localparam logic [OP_W-1:0] OP_ADDI  = 16'h2000;
    localparam logic [OP_W-1:0] OP_RET   = 16'h0800;
    localparam logic [OP_W-1:0] OP_CSRW  = 16'h0200;
    localparam logic [OP_W-1:0] OP_CSRR  = 16'h0100;

    localparam logic [IMM_W-1:0] CSR_MCCTLBEGINADDR = 12'h7cb;
    localparam logic [IMM_W-1:0] CSR_UCCTLBEGINADDR = 12'h80b;
    localparam logic [IMM_W-1:0] CSR_MCCTLCOMMAND   = 12'h7cc;
    localparam logic [IMM_W-1:0] CSR_UCCTLCOMMAND   = 12'h80c;
    localparam logic [IMM_W-1:0] CSR_MCCTLDATA      = 12'h7cd;
    localparam logic [IMM_W-1:0] CSR_UCCTLDATA      = 12'h80d;

    localparam logic REQ_PP   = 1'b0;
    localparam logic REQ_CCTL = 1'b1;

    localparam logic [KIND_W-1:0] PP_PUSH   = 2'd0;
    localparam logic [KIND_W-1:0] PP_POP    = 2'd1;
    localparam logic [KIND_W-1:0] PP_POPRET = 2'd2;

    localparam logic [PC_W-1:0] PP_STEP_ADJ = 4'd14;
    localparam logic [PC_W-1:0] PP_STEP_RET = 4'd15;

    localparam logic [REG_W-1:0] SP_REG = 5'd2;
    localparam logic [REG_W-1:0] RA_REG = 5'd1;

    // arbiter states
    localparam logic [1:0] ARB_IDLE  = 2'd0;
    localparam logic [1:0] ARB_RUN   = 2'd1;
    localparam logic [1:0] ARB_DRAIN = 2'd2;

    typedef union packed {
        logic [UOP_W-1:0] raw;      // issue port view
        struct packed {
            logic              xcpt;
            logic              last;
            logic              serial;
            logic [REG_W-1:0]  rs;
            logic [REG_W-1:0]  rd;
            logic [OP_W-1:0]   op;
            logic [IMM_W-1:0]  imm;
        } f;
    } uop_word_u;

    // register list order: ra, s0, s1, then s2..s11
    function automatic logic [REG_W-1:0] reg_of_slot(input logic [CNT_W-1:0] k);
        logic [REG_W-1:0] r;
        case (k)
            4'd0:    r = 5'd1;
            4'd1:    r = 5'd8;
            4'd2:    r = 5'd9;
            default: r = REG_W'(k) + 5'd15;
        endcase
        return r;
    endfunction

endpackage

`default_nettype wire

// ==== design/uop_prgbuf.sv ====
// program buffer: micro-op PC and owner, push/pop and cache-control decode, issue register
`default_nettype none
`timescale 1ns/1ps

module uop_prgbuf (
    input  logic                          core_clk,
    input  logic                          core_reset_n,
    input  logic                          uop_stall,
    input  logic                          buf_load,
    input  logic [uop_pkg::PC_W-1:0]      buf_pc,
    input  logic                          buf_owner,
    input  logic                          buf_last,
    input  logic                          priv_m,
    input  logic [uop_pkg::KIND_W-1:0]    pp_kind,
    input  logic [uop_pkg::CNT_W-1:0]     pp_rcount,
    input  logic [uop_pkg::IMM_W-1:0]     pp_stackadj,
    input  logic [uop_pkg::CMD_W-1:0]     cctl_cmd,
    input  logic [uop_pkg::REG_W-1:0]     cctl_rs,
    input  logic [uop_pkg::REG_W-1:0]     cctl_rd,
    output logic                          buf_free,
    output logic                          uop_valid,
    output uop_pkg::uop_word_u            uop_word
);

    logic [uop_pkg::PC_W-1:0] pc_q;
    logic                     owner_q;
    logic                     last_q;
    logic                     priv_q;
    logic                     pc_busy;     // a step sits in the PC
    uop_pkg::uop_word_u       pp_word;
    uop_pkg::uop_word_u       cctl_word;
    uop_pkg::uop_word_u       dec_word;

    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            pc_q    <= '0;
            owner_q <= uop_pkg::REQ_PP;
            last_q  <= 1'b0;
            priv_q  <= 1'b0;
            pc_busy <= 1'b0;
        end else if (buf_load) begin
            pc_q    <= buf_pc;
            owner_q <= buf_owner;
            last_q  <= buf_last;
            priv_q  <= priv_m;
            pc_busy <= 1'b1;
        end else if (!uop_stall) begin
            pc_busy <= 1'b0;
        end
    end

    assign buf_free = !pc_busy || (last_q && !uop_stall);

    always_comb begin : pp_body
        logic [uop_pkg::IMM_W-1:0] slot_off;
        slot_off = {{(uop_pkg::IMM_W - uop_pkg::PC_W - 2){1'b0}}, pc_q, 2'b00} + 12'd4;
        pp_word  = '0;
        if (pc_q == uop_pkg::PP_STEP_ADJ) begin
            pp_word.f.op  = uop_pkg::OP_ADDI;
            pp_word.f.rs  = uop_pkg::SP_REG;
            pp_word.f.rd  = uop_pkg::SP_REG;
            pp_word.f.imm = (pp_kind == uop_pkg::PP_PUSH) ? 12'd0 - pp_stackadj : pp_stackadj;
        end else if (pc_q == uop_pkg::PP_STEP_RET) begin
            pp_word.f.op = uop_pkg::OP_RET;
            pp_word.f.rs = uop_pkg::RA_REG;
        end else if (pc_q < pp_rcount) begin
            pp_word.f.rs = uop_pkg::SP_REG;
            pp_word.f.rd = uop_pkg::reg_of_slot(pc_q);
            if (pp_kind == uop_pkg::PP_PUSH) begin
                pp_word.f.op  = uop_pkg::OP_STORE;
                pp_word.f.imm = 12'd0 - slot_off;          // below the old sp
            end else begin
                pp_word.f.op  = uop_pkg::OP_LOAD;
                pp_word.f.imm = pp_stackadj - slot_off;    // sp still at the low end
            end
        end
    end

    // machine CSRs in M mode, user CSRs otherwise
    always_comb begin : cctl_body
        cctl_word = '0;
        case (pc_q)
            'd0: begin
                cctl_word.f.op  = uop_pkg::OP_CSRW;
                cctl_word.f.rs  = cctl_rs;
                cctl_word.f.imm = priv_q ? uop_pkg::CSR_MCCTLBEGINADDR
                                         : uop_pkg::CSR_UCCTLBEGINADDR;
            end
            'd1: begin
                cctl_word.f.op     = uop_pkg::OP_CSRW;
                cctl_word.f.serial = 1'b1;
                cctl_word.f.xcpt   = !priv_q && cctl_cmd[6];   // M-only command
                cctl_word.f.imm    = priv_q ? uop_pkg::CSR_MCCTLCOMMAND
                                            : uop_pkg::CSR_UCCTLCOMMAND;
            end
            'd2: begin
                cctl_word.f.op  = uop_pkg::OP_CSRR;
                cctl_word.f.rd  = cctl_rd;
                cctl_word.f.imm = priv_q ? uop_pkg::CSR_MCCTLDATA : uop_pkg::CSR_UCCTLDATA;
            end
            default: cctl_word = '0;
        endcase
    end

    always_comb begin : word_sel
        dec_word = (owner_q == uop_pkg::REQ_CCTL) ? cctl_word : pp_word;
        dec_word.f.last = last_q;
    end

    // issue stage
    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            uop_valid <= 1'b0;
        end else if (!uop_stall) begin
            uop_valid <= pc_busy;
        end
    end

    always_ff @(posedge core_clk) begin
        if (!uop_stall) begin
            uop_word <= dec_word;
        end
    end

    hold_under_stall: assert property (
        @(posedge core_clk) disable iff (!core_reset_n)
        (uop_valid && uop_stall) |=> (uop_valid && $stable(uop_word.raw))
    );

    no_load_in_stall: assert property (
        @(posedge core_clk) disable iff (!core_reset_n) buf_load |-> !uop_stall
    );

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+test
design/uop_pkg.sv
design/pp_seq.sv
design/cctl_seq.sv
design/uop_arbiter.sv
design/uop_prgbuf.sv
design/uop_expander.sv
test/uop_expander_tb.sv

// ==== test/uop_checks.svh ====
// compare tasks for micro-op words and busy levels, mismatch and timeout reporting
`ifndef UOP_CHECKS_SVH
`define UOP_CHECKS_SVH

task automatic report_mismatch(input string msg);
    errors++;
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    end_in_failure();
endtask

task automatic check_uop(
    input uop_pkg::uop_word_u got,
    input uop_pkg::uop_word_u exp,
    input string              what
);
    if (got.raw !== exp.raw) begin
        report_mismatch($sformatf(
            "%s: word %h expected %h (op %h/%h rs %0d/%0d rd %0d/%0d imm %h/%h)",
            what, got.raw, exp.raw, got.f.op, exp.f.op, got.f.rs, exp.f.rs,
            got.f.rd, exp.f.rd, got.f.imm, exp.f.imm));
    end
endtask

task automatic check_busy(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
    end
endtask

task automatic check_count(input integer got, input integer exp, input string what);
    if (got != exp) begin
        report_mismatch($sformatf("%s: %0d words issued, expected %0d", what, got, exp));
    end
endtask

task automatic report_timeout(input string what);
    $display("timeout at %0t ns: gave up waiting for %s", $time, what);
    end_in_failure();
endtask

`endif

// ==== test/uop_expander_tb.sv ====
// testbench for the micro-op expander: clock, reset, file-driven requests, word capture
`default_nettype none
`timescale 1ns/1ps

module uop_expander_tb;

    logic                          core_clk;
    logic                          core_reset_n;
    logic                          uop_stall;
    logic                          pp_req;
    logic [uop_pkg::KIND_W-1:0]    pp_kind;
    logic [uop_pkg::CNT_W-1:0]     pp_rcount;
    logic [uop_pkg::IMM_W-1:0]     pp_stackadj;
    logic                          cctl_req;
    logic [uop_pkg::CMD_W-1:0]     cctl_cmd;
    logic [uop_pkg::REG_W-1:0]     cctl_rs;
    logic [uop_pkg::REG_W-1:0]     cctl_rd;
    logic                          priv_m;
    logic                          pp_busy;
    logic                          cctl_busy;
    logic                          uop_valid;
    uop_pkg::uop_word_u            uop_word;

    integer              seed;
    integer              errors;
    integer              rnd;
    logic                stall_on;
    uop_pkg::uop_word_u  got_q[$];     // words taken by the pipeline
    uop_pkg::uop_word_u  exp_q[$];

    uop_expander UUT (
        .core_clk(core_clk), .core_reset_n(core_reset_n), .uop_stall(uop_stall),
        .pp_req(pp_req), .pp_kind(pp_kind), .pp_rcount(pp_rcount), .pp_stackadj(pp_stackadj),
        .cctl_req(cctl_req), .cctl_cmd(cctl_cmd), .cctl_rs(cctl_rs), .cctl_rd(cctl_rd),
        .priv_m(priv_m), .pp_busy(pp_busy), .cctl_busy(cctl_busy),
        .uop_valid(uop_valid), .uop_word(uop_word)
    );

    task automatic end_in_failure();
        $display("Simulation failed");
        $fatal(1);
    endtask

    `include "uop_checks.svh"

    initial begin
        core_clk = 1'b0;
        forever #20 core_clk = ~core_clk;
    end

    always @(posedge core_clk) begin
        if (stall_on) begin
            rnd = $random(seed);
            uop_stall <= rnd[0];
        end else begin
            uop_stall <= 1'b0;
        end
    end

    always @(posedge core_clk) begin
        if (core_reset_n && uop_valid && !uop_stall) begin
            got_q.push_back(uop_word);
        end
    end

    // skips blank lines and comment lines
    task automatic read_line(input integer fd, output string line, output bit ok);
        integer n;
        ok = 1'b0;
        while (!ok && !$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 1 && line[0] != "#") ok = 1'b1;
        end
    endtask

    task automatic run_test(input integer fd, input string line, input integer tnum);
        logic                          t_pp_en, t_cctl_en, t_priv, t_stall, t_again;
        logic                          t_busy_pp, t_busy_cctl;
        logic [uop_pkg::KIND_W-1:0]    t_kind;
        logic [uop_pkg::CNT_W-1:0]     t_rcount;
        logic [uop_pkg::IMM_W-1:0]     t_stackadj;
        logic [uop_pkg::CMD_W-1:0]     t_cmd;
        logic [uop_pkg::REG_W-1:0]     t_rs, t_rd;
        logic [uop_pkg::UOP_W-1:0]     raw_w;
        uop_pkg::uop_word_u            exp_w;
        integer                        t_count, n, cycles;
        string                         wline;
        bit                            ok;
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %d",
                    t_pp_en, t_kind, t_rcount, t_stackadj, t_cctl_en, t_cmd, t_rs, t_rd,
                    t_priv, t_stall, t_again, t_busy_pp, t_busy_cctl, t_count);
        if (n != 14) begin
            $display("malformed request line in test data: %s", line);
            end_in_failure();
        end
        exp_q.delete();
        for (int i = 0; i < t_count; i++) begin
            read_line(fd, wline, ok);
            if (!ok || $sscanf(wline, "%h", raw_w) != 1) begin
                $display("test %0d is missing expected words in the test data", tnum);
                end_in_failure();
            end
            exp_w.raw = raw_w;
            exp_q.push_back(exp_w);
        end
        got_q.delete();
        @(posedge core_clk);
        pp_kind     <= t_kind;
        pp_rcount   <= t_rcount;
        pp_stackadj <= t_stackadj;
        cctl_cmd    <= t_cmd;
        cctl_rs     <= t_rs;
        cctl_rd     <= t_rd;
        priv_m      <= t_priv;
        pp_req      <= t_pp_en;
        cctl_req    <= t_cctl_en;
        stall_on    <= t_stall;
        @(posedge core_clk);
        if (!t_again) begin
            pp_req   <= 1'b0;
            cctl_req <= 1'b0;
        end
        @(negedge core_clk);
        check_busy(pp_busy, t_busy_pp, $sformatf("test %0d pp_busy after request", tnum));
        check_busy(cctl_busy, t_busy_cctl, $sformatf("test %0d cctl_busy after request", tnum));
        if (t_again) begin
            @(posedge core_clk);        // repeated strobe is seen while busy
            pp_req   <= 1'b0;
            cctl_req <= 1'b0;
        end
        cycles = 0;
        while (got_q.size() < t_count) begin
            @(negedge core_clk);
            cycles++;
            if (cycles > 400) report_timeout($sformatf("words of test %0d", tnum));
        end
        // busy drops as the last word enters the issue register, before it is taken
        check_busy(pp_busy, 1'b0, $sformatf("test %0d pp_busy at end", tnum));
        check_busy(cctl_busy, 1'b0, $sformatf("test %0d cctl_busy at end", tnum));
        @(posedge core_clk);
        stall_on <= 1'b0;
        repeat (4) @(negedge core_clk);     // any extra word would show up here
        check_count(got_q.size(), t_count, $sformatf("test %0d", tnum));
        foreach (exp_q[i]) begin
            check_uop(got_q[i], exp_q[i], $sformatf("test %0d word %0d", tnum, i));
        end
    endtask

    initial begin
        integer fd;
        integer tnum;
        string  line;
        bit     ok;
        core_reset_n = 1'b0;
        uop_stall    = 1'b0;
        pp_req       = 1'b0;
        pp_kind      = '0;
        pp_rcount    = 4'd1;
        pp_stackadj  = '0;
        cctl_req     = 1'b0;
        cctl_cmd     = '0;
        cctl_rs      = '0;
        cctl_rd      = '0;
        priv_m       = 1'b1;
        seed         = 86;
        errors       = 0;
        stall_on     = 1'b0;
        tnum         = 0;
        repeat (10) @(posedge core_clk);
        core_reset_n <= 1'b1;
        @(negedge core_clk);
        check_busy(pp_busy, 1'b0, "pp_busy after reset");
        check_busy(cctl_busy, 1'b0, "cctl_busy after reset");
        fd = $fopen("test/uop_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open test/uop_tests.txt");
            end_in_failure();
        end
        read_line(fd, line, ok);
        while (ok) begin
            run_test(fd, line, tnum);
            tnum++;
            read_line(fd, line, ok);
        end
        $fclose(fd);
        if (tnum == 0) begin
            $display("no tests were read from test/uop_tests.txt");
            errors++;
        end
        if (errors == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            end_in_failure();
        end
    end

endmodule

`default_nettype wire

// ==== test/uop_tests.txt ====
# request (hex, count decimal): pp_en kind rcount stackadj cctl_en cmd rs rd priv_m stall again pp_busy cctl_busy count
# followed by count expected 41-bit raw micro-op words in hex, in issue order
1 0 2 010 1 05 0a 0b 1 0 0 1 1 5
00418000ffc
00488000ff8
08422000ff0
014002007cb
0c0002007cc
1 1 1 020 0 00 00 00 1 0 0 1 0 2
0041400001c
08422000020
1 2 3 030 1 80 05 06 0 0 0 1 1 8
00a0020080b
0400020080c
0806010080d
0041400002c
00484000028
00494000024
00422000030
08200800000
0 0 1 000 1 c3 1f 11 0 1 0 0 1 3
03e0020080b
1400020080c
0811010080d
0 0 1 000 1 40 01 02 1 0 1 0 1 2
002002007cb
0c0002007cc
1 0 d 040 0 00 00 00 1 1 1 1 0 14
00418000ffc
00488000ff8
00498000ff4
00528000ff0
00538000fec
00548000fe8
00558000fe4
00568000fe0
00578000fdc
00588000fd8
00598000fd4
005a8000fd0
005b8000fcc
08422000fc0
1 2 1 010 0 00 00 00 1 1 0 1 0 3
0041400000c
00422000010
08200800000
1 0 1 008 1 41 03 04 0 1 0 1 1 4
0060020080b
1c00020080c
00418000ffc
08422000ff8
